/* Bender.yml */
package:
  name: eth_fgp_rx

sources:
  - hw/fgp_pkg.sv
  - hw/dibits_to_bytes.sv
  - hw/eth_frame_parser.sv
  - hw/fgp_rx.sv
  - hw/bytes_to_colors.sv
  - hw/stream_to_memory.sv
  - hw/eth_fgp_rx.sv
  - target: test
    files:
      - test/eth_fgp_rx_properties.sv
      - test/tb_eth_fgp_rx.sv

/* files.f */
hw/fgp_pkg.sv
hw/dibits_to_bytes.sv
hw/eth_frame_parser.sv
hw/fgp_rx.sv
hw/bytes_to_colors.sv
hw/stream_to_memory.sv
hw/eth_fgp_rx.sv
test/eth_fgp_rx_properties.sv
test/tb_eth_fgp_rx.sv

/* hw/bytes_to_colors.sv */
`default_nettype none

module bytes_to_colors
	import fgp_pkg::*;
(
	input  logic   clk,
	input  logic   eth_rx_downstream_rst,
	input  logic   in_valid,
	input  byte_t  in,
	input  logic   in_done,
	output logic   out_valid,
	output color_t out
);

	// Position of the incoming byte in its group of three
	logic [1:0] cnt;
	byte_t prev;

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			cnt <= '0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= 1'b0;
			if (in_done) begin
				cnt <= '0;
			end else if (in_valid) begin
				if (cnt == 2'd2) begin
					cnt <= '0;
				end else begin
					cnt <= cnt + 1'b1;
				end
				out_valid <= cnt != 2'd0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			prev <= in;
			case (cnt)
				// b0 then high nibble of b1
				2'd1: out <= {prev, in[BYTE_LEN-1:BYTE_LEN/2]};
				// low nibble of b1 then b2
				2'd2: out <= {prev[BYTE_LEN/2-1:0], in};
				default: out <= out;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/dibits_to_bytes.sv */
`default_nettype none

module dibits_to_bytes
	import fgp_pkg::*;
(
	input  logic   clk,
	input  logic   eth_rx_downstream_rst,
	input  logic   in_valid,
	input  dibit_t in,
	input  logic   in_done,
	output logic   out_valid,
	output byte_t  out,
	output logic   done
);

	logic [$clog2(DIBITS_PER_BYTE)-1:0] cnt;
	byte_t shreg;
	byte_t next_byte;

	// RMII sends the least significant dibit first, so new dibits enter at the top
	assign next_byte = {in, shreg[BYTE_LEN-1:DIBIT_LEN]};

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			cnt <= '0;
			out_valid <= 1'b0;
			done <= 1'b0;
		end else begin
			out_valid <= 1'b0;
			done <= in_done;
			if (in_done) begin
				// Drop any partial byte so the next frame starts aligned
				cnt <= '0;
			end else if (in_valid) begin
				cnt <= cnt + 1'b1;
				if (cnt == ($bits(cnt))'(DIBITS_PER_BYTE - 1)) begin
					out_valid <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			shreg <= next_byte;
			if (cnt == ($bits(cnt))'(DIBITS_PER_BYTE - 1)) begin
				out <= next_byte;
			end
		end
	end

endmodule

`default_nettype wire

/* hw/eth_fgp_rx.sv */
`default_nettype none

module eth_fgp_rx
	import fgp_pkg::*;
(
	input  logic       clk,
	input  logic       eth_rx_downstream_rst,
	input  logic       dibit_valid,
	input  dibit_t     dibit,
	input  logic       frame_done,
	output logic       vram_we,
	output vram_addr_t vram_waddr,
	output color_t     vram_win
);

	logic dtb_valid;
	byte_t dtb_byte;
	logic dtb_done;

	logic parse_valid;
	byte_t parse_byte;
	logic parse_done;

	logic fgp_offset_valid;
	fgp_offset_t fgp_offset;
	logic fgp_valid;
	byte_t fgp_byte;
	logic fgp_done;

	logic btc_valid;
	color_t btc_color;

	dibits_to_bytes dtb_inst (
		.clk                   (clk),
		.eth_rx_downstream_rst (eth_rx_downstream_rst),
		.in_valid              (dibit_valid),
		.in                    (dibit),
		.in_done               (frame_done),
		.out_valid             (dtb_valid),
		.out                   (dtb_byte),
		.done                  (dtb_done)
	);

	// Only FGP payload bytes leave the parser
	eth_frame_parser parser_inst (
		.clk                   (clk),
		.eth_rx_downstream_rst (eth_rx_downstream_rst),
		.in_valid              (dtb_valid),
		.in                    (dtb_byte),
		.in_done               (dtb_done),
		.out_valid             (parse_valid),
		.out                   (parse_byte),
		.done                  (parse_done)
	);

	fgp_rx fgp_rx_inst (
		.clk                   (clk),
		.eth_rx_downstream_rst (eth_rx_downstream_rst),
		.in_valid              (parse_valid),
		.in                    (parse_byte),
		.in_done               (parse_done),
		.offset_valid          (fgp_offset_valid),
		.offset                (fgp_offset),
		.out_valid             (fgp_valid),
		.out                   (fgp_byte),
		.done                  (fgp_done)
	);

	bytes_to_colors btc_inst (
		.clk                   (clk),
		.eth_rx_downstream_rst (eth_rx_downstream_rst),
		.in_valid              (fgp_valid),
		.in                    (fgp_byte),
		.in_done               (fgp_done),
		.out_valid             (btc_valid),
		.out                   (btc_color)
	);

	stream_to_memory stm_inst (
		.clk                   (clk),
		.eth_rx_downstream_rst (eth_rx_downstream_rst),
		.setoff_req            (fgp_offset_valid),
		.setoff_val            (fgp_offset),
		.in_valid              (btc_valid),
		.in                    (btc_color),
		.vram_we               (vram_we),
		.vram_waddr            (vram_waddr),
		.vram_win              (vram_win)
	);

endmodule

`default_nettype wire

/* hw/eth_frame_parser.sv */
`default_nettype none

module eth_frame_parser
	import fgp_pkg::*;
(
	input  logic  clk,
	input  logic  eth_rx_downstream_rst,
	input  logic  in_valid,
	input  byte_t in,
	input  logic  in_done,
	output logic  out_valid,
	output byte_t out,
	output logic  done
);

	parse_state_t state;
	logic [$clog2(ETH_HEADER_LEN)-1:0] hdr_cnt;
	byte_t ethertype_hi;
	ethertype_t ethertype_rx;
	logic last_hdr_byte;

	// Ethertype is big endian with the high byte one header byte earlier
	assign ethertype_rx = {ethertype_hi, in};
	assign last_hdr_byte = hdr_cnt == ($bits(hdr_cnt))'(ETH_HEADER_LEN - 1);

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			state <= PS_HEADER;
			hdr_cnt <= '0;
		end else if (in_done) begin
			state <= PS_HEADER;
			hdr_cnt <= '0;
		end else if (in_valid && state == PS_HEADER) begin
			hdr_cnt <= hdr_cnt + 1'b1;
			if (last_hdr_byte) begin
				if (ethertype_rx == ETHERTYPE_FGP) begin
					state <= PS_PAYLOAD;
				end else begin
					state <= PS_DISCARD;
				end
			end
		end
	end

	// High ethertype byte sits right after both MAC addresses
	always_ff @(posedge clk) begin
		if (in_valid && state == PS_HEADER &&
				hdr_cnt == ($bits(hdr_cnt))'(2 * ETH_MAC_LEN)) begin
			ethertype_hi <= in;
		end
	end

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			out_valid <= 1'b0;
			done <= 1'b0;
		end else begin
			out_valid <= in_valid && state == PS_PAYLOAD;
			done <= in_done;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			out <= in;
		end
	end

endmodule

`default_nettype wire

/* hw/fgp_pkg.sv */
`default_nettype none

package fgp_pkg;

	// Basic widths
	localparam int BYTE_LEN = 8;
	localparam int DIBIT_LEN = 2;
	localparam int DIBITS_PER_BYTE = BYTE_LEN / DIBIT_LEN;
	localparam int COLOR_LEN = 12;

	// Ethernet II header holds destination and source MAC then ethertype
	localparam int ETH_MAC_LEN = 6;
	localparam int ETH_ETHERTYPE_LEN = 2;
	localparam int ETH_HEADER_LEN = 2 * ETH_MAC_LEN + ETH_ETHERTYPE_LEN;

	// Frame-graphics packet
	localparam logic [ETH_ETHERTYPE_LEN*BYTE_LEN-1:0] ETHERTYPE_FGP = 16'h88b5;
	localparam int FGP_DATA_LEN = 48;
	localparam int FGP_DATA_LEN_COLORS = FGP_DATA_LEN * BYTE_LEN / COLOR_LEN;

	// Video memory
	localparam int VRAM_SIZE = 8192;
	localparam int VRAM_ADDR_LEN = $clog2(VRAM_SIZE);

	typedef logic [DIBIT_LEN-1:0] dibit_t;
	typedef logic [BYTE_LEN-1:0] byte_t;
	typedef logic [ETH_ETHERTYPE_LEN*BYTE_LEN-1:0] ethertype_t;
	typedef logic [BYTE_LEN-1:0] fgp_offset_t;
	typedef logic [COLOR_LEN-1:0] color_t;
	typedef logic [VRAM_ADDR_LEN-1:0] vram_addr_t;

	// Parser position within a frame
	typedef enum logic [1:0] {
		PS_HEADER,
		PS_PAYLOAD,
		PS_DISCARD
	} parse_state_t;

endpackage

`default_nettype wire

/* hw/fgp_rx.sv */
`default_nettype none

module fgp_rx
	import fgp_pkg::*;
(
	input  logic        clk,
	input  logic        eth_rx_downstream_rst,
	input  logic        in_valid,
	input  byte_t       in,
	input  logic        in_done,
	output logic        offset_valid,
	output fgp_offset_t offset,
	output logic        out_valid,
	output byte_t       out,
	output logic        done
);

	logic have_offset;
	logic [$clog2(FGP_DATA_LEN+1)-1:0] data_cnt;
	logic data_full;

	assign data_full = data_cnt == ($bits(data_cnt))'(FGP_DATA_LEN);

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			have_offset <= 1'b0;
			data_cnt <= '0;
			offset_valid <= 1'b0;
			out_valid <= 1'b0;
			done <= 1'b0;
		end else begin
			offset_valid <= 1'b0;
			out_valid <= 1'b0;
			done <= in_done;
			if (in_done) begin
				have_offset <= 1'b0;
				data_cnt <= '0;
			end else if (in_valid) begin
				if (!have_offset) begin
					have_offset <= 1'b1;
					offset_valid <= 1'b1;
				end else if (!data_full) begin
					// Bytes past the data block are dropped until done
					data_cnt <= data_cnt + 1'b1;
					out_valid <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			if (!have_offset) begin
				offset <= in;
			end
			out <= in;
		end
	end

endmodule

`default_nettype wire

/* hw/stream_to_memory.sv */
`default_nettype none

module stream_to_memory
	import fgp_pkg::*;
(
	input  logic        clk,
	input  logic        eth_rx_downstream_rst,
	input  logic        setoff_req,
	input  fgp_offset_t setoff_val,
	input  logic        in_valid,
	input  color_t      in,
	output logic        vram_we,
	output vram_addr_t  vram_waddr,
	output color_t      vram_win
);

	vram_addr_t wptr;

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			wptr <= '0;
			vram_we <= 1'b0;
		end else begin
			vram_we <= in_valid;
			if (setoff_req) begin
				// Each offset step is one packet's worth of colors
				wptr <= vram_addr_t'({setoff_val, {$clog2(FGP_DATA_LEN_COLORS){1'b0}}});
			end else if (in_valid) begin
				wptr <= wptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			vram_waddr <= wptr;
			vram_win <= in;
		end
	end

endmodule

`default_nettype wire

/* test/eth_fgp_rx_properties.sv */
`default_nettype none

module eth_fgp_rx_properties
	import fgp_pkg::*;
(
	input logic       clk,
	input logic       eth_rx_downstream_rst,
	input logic       setoff,
	input logic       vram_we,
	input vram_addr_t vram_waddr,
	input color_t     vram_win
);
	timeunit 1ns;
	timeprecision 1ps;

	int n_failures = 0;
	logic have_prev;
	vram_addr_t prev_addr;

	// Last written address is forgotten on reset or a new offset
	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst || setoff) begin
			have_prev <= 1'b0;
		end else if (vram_we) begin
			have_prev <= 1'b1;
			prev_addr <= vram_waddr;
		end
	end

	no_write_after_reset: assert property (@(posedge clk)
		eth_rx_downstream_rst |=> !vram_we)
	else begin
		n_failures++;
		$error("vram_we high in the cycle after reset");
	end

	win_known: assert property (@(posedge clk) disable iff (eth_rx_downstream_rst)
		vram_we |-> !$isunknown(vram_win))
	else begin
		n_failures++;
		$error("vram_win unknown during a write");
	end

	addr_step: assert property (@(posedge clk) disable iff (eth_rx_downstream_rst)
		vram_we && have_prev |-> vram_waddr == vram_addr_t'(prev_addr + 1'b1))
	else begin
		n_failures++;
		$error("write address did not advance by one");
	end

endmodule

bind eth_fgp_rx eth_fgp_rx_properties i_props (
	.clk                   (clk),
	.eth_rx_downstream_rst (eth_rx_downstream_rst),
	.setoff                (fgp_offset_valid),
	.vram_we               (vram_we),
	.vram_waddr            (vram_waddr),
	.vram_win              (vram_win)
);

`default_nettype wire

/* test/tb_eth_fgp_rx.sv */
`default_nettype none

module tb_eth_fgp_rx
	import fgp_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DELAY = 10;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_FRAMES = 16;
	localparam int MAX_PAYLOAD = 64;
	localparam int WATCHDOG_CYCLES =
		NUM_FRAMES * (ETH_HEADER_LEN + 1 + MAX_PAYLOAD) * DIBITS_PER_BYTE * 3 + 1000;

	logic clk;
	logic eth_rx_downstream_rst;
	logic dibit_valid;
	dibit_t dibit;
	logic frame_done;
	logic vram_we;
	vram_addr_t vram_waddr;
	color_t vram_win;

	logic [31:0] rng_state;
	byte_t frame_bytes[$];

	// Expected writes with the oldest first
	vram_addr_t exp_addr_q[$];
	color_t exp_color_q[$];
	string exp_name_q[$];

	int n_value_errors = 0;
	int n_unexpected = 0;
	int n_missing = 0;

	eth_fgp_rx i_dut (
		.clk                   (clk),
		.eth_rx_downstream_rst (eth_rx_downstream_rst),
		.dibit_valid           (dibit_valid),
		.dibit                 (dibit),
		.frame_done            (frame_done),
		.vram_we               (vram_we),
		.vram_waddr            (vram_waddr),
		.vram_win              (vram_win)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic int rand_below(input int n);
		logic [31:0] r;
		r = next_random();
		return int'(r % n);
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	task automatic send_dibit(input dibit_t d, input int gap);
		repeat (gap) begin
			dibit_valid = 1'b0;
			next_cycle();
		end
		dibit_valid = 1'b1;
		dibit = d;
		next_cycle();
		dibit_valid = 1'b0;
	endtask

	// Bytes go out least significant dibit first
	task automatic send_bytes(input int count, input int max_gap);
		byte_t b;
		int gap;
		for (int i = 0; i < count; i++) begin
			b = frame_bytes[i];
			for (int d = 0; d < DIBITS_PER_BYTE; d++) begin
				gap = (max_gap == 0) ? 0 : rand_below(max_gap + 1);
				send_dibit(b[DIBIT_LEN*d +: DIBIT_LEN], gap);
			end
		end
	endtask

	task automatic send_frame(input int max_gap);
		send_bytes(frame_bytes.size(), max_gap);
		frame_done = 1'b1;
		next_cycle();
		frame_done = 1'b0;
	endtask

	// Two MAC addresses, ethertype, offset byte, then n_data data bytes
	task automatic make_frame(input bit is_fgp, input int n_data);
		logic [31:0] r;
		ethertype_t et;
		frame_bytes.delete();
		for (int i = 0; i < 2 * ETH_MAC_LEN + 1 + n_data + ETH_ETHERTYPE_LEN; i++) begin
			r = next_random();
			frame_bytes.push_back(r[BYTE_LEN-1:0]);
		end
		et = ETHERTYPE_FGP;
		while (!is_fgp && et == ETHERTYPE_FGP) begin
			r = next_random();
			et = r[15:0];
		end
		frame_bytes[2 * ETH_MAC_LEN] = et[15:8];
		frame_bytes[2 * ETH_MAC_LEN + 1] = et[7:0];
	endtask

	// Reference model of the write list for the frame in frame_bytes
	task automatic push_expected_writes(input string name);
		vram_addr_t addr;
		byte_t prev;
		byte_t cur;
		int n;
		addr = vram_addr_t'(frame_bytes[ETH_HEADER_LEN] * FGP_DATA_LEN_COLORS);
		n = frame_bytes.size() - ETH_HEADER_LEN - 1;
		if (n > FGP_DATA_LEN) begin
			n = FGP_DATA_LEN;
		end
		prev = '0;
		for (int i = 0; i < n; i++) begin
			cur = frame_bytes[ETH_HEADER_LEN + 1 + i];
			if (i % 3 != 0) begin
				if (i % 3 == 1) begin
					exp_color_q.push_back({prev, cur[7:4]});
				end else begin
					exp_color_q.push_back({prev[3:0], cur});
				end
				exp_addr_q.push_back(addr);
				exp_name_q.push_back(name);
				addr = addr + 1'b1;
			end
			prev = cur;
		end
	endtask

	task automatic run_frame(input string name, input bit is_fgp, input int n_data,
			input int max_gap);
		make_frame(is_fgp, n_data);
		if (is_fgp) begin
			push_expected_writes(name);
		end
		send_frame(max_gap);
	endtask

	task automatic check_addr(input string name, input vram_addr_t expected,
			input vram_addr_t actual);
		if (actual !== expected) begin
			n_value_errors++;
			$display("** Error %s: address expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_color(input string name, input color_t expected,
			input color_t actual);
		if (actual !== expected) begin
			n_value_errors++;
			$display("** Error %s: color expected %h, actual %h", name, expected, actual);
		end
	endtask

	always @(negedge clk) begin : write_monitor
		string name;
		if (vram_we === 1'b1) begin
			if (exp_addr_q.size() == 0) begin
				n_unexpected++;
				$display("Unexpected write of color %h to address %h at %0t",
					vram_win, vram_waddr, $time);
			end else begin
				name = exp_name_q.pop_front();
				check_addr(name, exp_addr_q.pop_front(), vram_waddr);
				check_color(name, exp_color_q.pop_front(), vram_win);
			end
		end
	end

	initial begin
		byte_t cut_byte;
		int waited;
		int n_assert;
		rng_state = 32'h901c;
		eth_rx_downstream_rst = 1'b1;
		dibit_valid = 1'b0;
		dibit = '0;
		frame_done = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		eth_rx_downstream_rst = 1'b0;

		repeat (3) run_frame("fgp_full", 1'b1, FGP_DATA_LEN, 0);
		repeat (2) run_frame("other_ethertype", 1'b0, FGP_DATA_LEN, 0);
		repeat (2) run_frame("long_payload", 1'b1, FGP_DATA_LEN + 1 + rand_below(15), 0);
		repeat (3) run_frame("short_payload", 1'b1, 1 + rand_below(FGP_DATA_LEN - 1), 0);
		for (int i = 0; i < 4; i++) begin
			repeat (rand_below(4)) next_cycle();
			run_frame("idle_gaps", i != 2, 1 + rand_below(MAX_PAYLOAD - 1), 2);
		end

		// Cut a frame off in the middle of a data byte
		make_frame(1'b1, FGP_DATA_LEN);
		push_expected_writes("reset_mid_frame");
		send_bytes(ETH_HEADER_LEN + 1 + 20, 0);
		cut_byte = frame_bytes[ETH_HEADER_LEN + 1 + 20];
		send_dibit(cut_byte[1:0], 0);
		send_dibit(cut_byte[3:2], 0);
		eth_rx_downstream_rst = 1'b1;
		next_cycle();
		// Writes still in the pipeline are lost with the reset
		exp_addr_q.delete();
		exp_color_q.delete();
		exp_name_q.delete();
		repeat (3) next_cycle();
		eth_rx_downstream_rst = 1'b0;
		repeat (5) next_cycle();
		run_frame("after_reset", 1'b1, FGP_DATA_LEN, 0);

		waited = 0;
		while (exp_addr_q.size() != 0 && waited < 1000) begin
			next_cycle();
			waited++;
		end
		repeat (20) next_cycle();
		if (exp_addr_q.size() != 0) begin
			n_missing = exp_addr_q.size();
			$display("%0d expected writes never appeared, the first from test %s",
				n_missing, exp_name_q[0]);
		end

		n_assert = i_dut.i_props.n_failures;
		$display("Errors: %0d values, %0d unexpected, %0d missing, %0d assertions",
			n_value_errors, n_unexpected, n_missing, n_assert);
		if (n_value_errors + n_unexpected + n_missing + n_assert == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
